//--- rtl/clock_pkg.sv
package clock_pkg;

    // ------------------------------------------------------------
    // Time and button types
    // ------------------------------------------------------------

    localparam logic [7:0] MAX_SEC = 8'd59;
    localparam logic [7:0] MAX_MIN = 8'd59;

    typedef struct packed {
        logic [7:0] min;  // Binary 0..59
        logic [7:0] sec;  // Binary 0..59
    } clock_time_t;

    // Bit 0 is run so the struct lines up with button[2:0]
    typedef struct packed {
        logic inc_min;
        logic inc_sec;
        logic run;
    } face_btn_t;

    typedef enum logic {
        FACE_WATCH = 1'b0,
        FACE_COOK  = 1'b1
    } face_t;

    // ------------------------------------------------------------
    // Display word and segment patterns
    // ------------------------------------------------------------

    typedef union packed {
        struct packed {
            logic [7:0] high;  // Minutes as two BCD digits
            logic [7:0] low;   // Seconds as two BCD digits
        } field;
        logic [3:0][3:0] digit;  // digit[0] is the rightmost one
    } display_word_u;

    // Active low {dp,g,f,e,d,c,b,a}, dp kept dark
    localparam logic [7:0] SEG_TABLE [0:9] = '{
        8'hC0, 8'hF9, 8'hA4, 8'hB0, 8'h99,
        8'h92, 8'h82, 8'hF8, 8'h80, 8'h90
    };

    // Add one and wrap to zero past the limit
    function automatic logic [7:0] wrap_inc(input logic [7:0] value, input logic [7:0] limit);
        return (value >= limit) ? 8'd0 : value + 8'd1;
    endfunction

endpackage

//--- rtl/panel_control.sv
`timescale 1ns/1ps

module panel_control #(
    parameter int TICKS_PER_SEC = 100_000_000
) (
    input  logic                  clk,
    input  logic                  reset_p,
    input  logic [3:0]            button,
    output clock_pkg::face_btn_t  watch_btn,
    output clock_pkg::face_btn_t  cook_btn,
    output clock_pkg::face_t      face,
    output logic                  tick
);

    import clock_pkg::*;

    localparam int TICK_W = $clog2(TICKS_PER_SEC);

    logic [3:0]        btn_sync;  // Buttons sampled once
    logic [3:0]        btn_prev;  // Previous sample
    logic [3:0]        btn_pedge;
    logic [TICK_W-1:0] tick_cnt;
    face_btn_t         pulse;

    // ------------------------------------------------------------
    // Rising edges of the clean button levels
    // ------------------------------------------------------------

    always_ff @(posedge clk or posedge reset_p) begin
        if (reset_p) begin
            btn_sync <= '0;
            btn_prev <= '0;
        end else begin
            btn_sync <= button;
            btn_prev <= btn_sync;
        end
    end

    assign btn_pedge = btn_sync & ~btn_prev;  // High for one cycle after the sample
    assign pulse     = face_btn_t'(btn_pedge[2:0]);

    always_ff @(posedge clk or posedge reset_p) begin
        if (reset_p) begin
            face <= FACE_WATCH;
        end else if (btn_pedge[3]) begin
            face <= (face == FACE_WATCH) ? FACE_COOK : FACE_WATCH;
        end
    end

    // Only the face on show sees the buttons
    assign watch_btn = (face == FACE_WATCH) ? pulse : '0;
    assign cook_btn  = (face == FACE_COOK)  ? pulse : '0;

    // ------------------------------------------------------------
    // Shared one second tick
    // ------------------------------------------------------------

    always_ff @(posedge clk or posedge reset_p) begin
        if (reset_p) begin
            tick_cnt <= '0;
        end else if (tick) begin
            tick_cnt <= '0;
        end else begin
            tick_cnt <= tick_cnt + 1'b1;
        end
    end

    assign tick = (tick_cnt == TICK_W'(TICKS_PER_SEC - 1));

    // A press never reaches both cores, even across a face toggle
    a_one_face_only: assert property (@(posedge clk) disable iff (reset_p)
        !((|watch_btn) && (|cook_btn)));

endmodule

//--- rtl/watch_core.sv
`timescale 1ns/1ps

module watch_core (
    input  logic                    clk,
    input  logic                    reset_p,
    input  clock_pkg::face_btn_t    btn,
    input  logic                    tick,
    output clock_pkg::clock_time_t  time_out,
    output logic                    running
);

    import clock_pkg::*;

    logic run_next;  // Run state once the button has acted
    logic inc_any;
    logic advance;

    assign run_next = running ^ btn.run;
    assign inc_any  = btn.inc_sec | btn.inc_min;
    assign advance  = tick & run_next & ~inc_any;  // Increment wins over the tick

    always_ff @(posedge clk or posedge reset_p) begin
        if (reset_p) begin
            running <= 1'b1;  // Free running out of reset
        end else begin
            running <= run_next;
        end
    end

    always_ff @(posedge clk or posedge reset_p) begin
        if (reset_p) begin
            time_out <= '0;
        end else if (inc_any) begin
            // Each field on its own, no carry
            if (btn.inc_sec) begin
                time_out.sec <= wrap_inc(time_out.sec, MAX_SEC);
            end
            if (btn.inc_min) begin
                time_out.min <= wrap_inc(time_out.min, MAX_MIN);
            end
        end else if (advance) begin
            if (time_out.sec == MAX_SEC) begin
                time_out.sec <= 8'd0;
                time_out.min <= wrap_inc(time_out.min, MAX_MIN);  // 59:59 back to 00:00
            end else begin
                time_out.sec <= time_out.sec + 8'd1;
            end
        end
    end

    a_fields_in_range: assert property (@(posedge clk) disable iff (reset_p)
        (time_out.sec <= MAX_SEC) && (time_out.min <= MAX_MIN));

endmodule

//--- rtl/cook_timer.sv
`timescale 1ns/1ps

module cook_timer (
    input  logic                    clk,
    input  logic                    reset_p,
    input  clock_pkg::face_btn_t    btn,
    input  logic                    tick,
    input  logic                    alarm_off,
    output clock_pkg::clock_time_t  time_out,
    output logic                    running,
    output logic                    alarm
);

    import clock_pkg::*;

    logic time_zero;
    logic last_sec;  // 00:01 on the clock
    logic set_en;    // Increment while stopped
    logic run_next;
    logic count;
    logic alarm_hit;

    assign time_zero = (time_out == '0);
    assign last_sec  = (time_out.min == 8'd0) && (time_out.sec == 8'd1);
    assign set_en    = ~running & (btn.inc_sec | btn.inc_min);

    // Start only with something on the clock
    always_comb begin
        if (running) begin
            run_next = ~btn.run;
        end else begin
            run_next = btn.run & ~time_zero;
        end
    end

    assign count     = tick & run_next & ~set_en;
    assign alarm_hit = count & last_sec;

    always_ff @(posedge clk or posedge reset_p) begin
        if (reset_p) begin
            running <= 1'b0;
        end else if (alarm_hit) begin
            running <= 1'b0;  // Stop at 00:00
        end else begin
            running <= run_next;
        end
    end

    always_ff @(posedge clk or posedge reset_p) begin
        if (reset_p) begin
            time_out <= '0;
        end else if (set_en) begin
            if (btn.inc_sec) begin
                time_out.sec <= wrap_inc(time_out.sec, MAX_SEC);
            end
            if (btn.inc_min) begin
                time_out.min <= wrap_inc(time_out.min, MAX_MIN);
            end
        end else if (count) begin
            if (time_out.sec == 8'd0) begin
                time_out.sec <= MAX_SEC;           // Borrow a minute
                time_out.min <= time_out.min - 8'd1;
            end else begin
                time_out.sec <= time_out.sec - 8'd1;
            end
        end
    end

    // Switch off beats a fresh alarm in the same cycle
    always_ff @(posedge clk or posedge reset_p) begin
        if (reset_p) begin
            alarm <= 1'b0;
        end else if (alarm_off) begin
            alarm <= 1'b0;
        end else if (alarm_hit) begin
            alarm <= 1'b1;
        end
    end

    a_no_run_at_zero: assert property (@(posedge clk) disable iff (reset_p)
        !(running && time_zero));

endmodule

//--- rtl/display_mux.sv
`timescale 1ns/1ps

module display_mux (
    input  clock_pkg::face_t          face,
    input  clock_pkg::clock_time_t    watch_time,
    input  clock_pkg::clock_time_t    cook_time,
    output clock_pkg::display_word_u  disp
);

    import clock_pkg::*;

    clock_time_t shown;

    // Two BCD digits from a binary value of at most 59
    function automatic logic [7:0] to_bcd(input logic [7:0] bin);
        logic [3:0] tens;
        logic [7:0] rest;
        tens = 4'd0;
        rest = bin;
        for (int i = 0; i < 5; i++) begin
            if (rest >= 8'd10) begin
                rest = rest - 8'd10;
                tens = tens + 4'd1;
            end
        end
        return {tens, rest[3:0]};
    endfunction

    assign shown = (face == FACE_COOK) ? cook_time : watch_time;

    always_comb begin
        disp            = '0;
        disp.field.high = to_bcd(shown.min);  // Left pair of digits
        disp.field.low  = to_bcd(shown.sec);  // Right pair
    end

endmodule

//--- rtl/fnd_scan.sv
`timescale 1ns/1ps

module fnd_scan #(
    parameter int SCAN_CYCLES = 100_000
) (
    input  logic                      clk,
    input  logic                      reset_p,
    input  clock_pkg::display_word_u  disp,
    output logic [7:0]                seg,
    output logic [3:0]                com
);

    import clock_pkg::*;

    localparam int SCAN_W = $clog2(SCAN_CYCLES);

    logic [SCAN_W-1:0] scan_cnt;
    logic [1:0]        digit_idx;  // 0 is the rightmost digit
    logic              scan_step;
    logic [3:0]        cur_digit;

    // ------------------------------------------------------------
    // Scan period and digit index
    // ------------------------------------------------------------

    assign scan_step = (scan_cnt == SCAN_W'(SCAN_CYCLES - 1));

    always_ff @(posedge clk or posedge reset_p) begin
        if (reset_p) begin
            scan_cnt  <= '0;
            digit_idx <= 2'd0;
        end else if (scan_step) begin
            scan_cnt  <= '0;
            digit_idx <= digit_idx + 2'd1;  // Wraps 3 to 0
        end else begin
            scan_cnt  <= scan_cnt + 1'b1;
        end
    end

    // ------------------------------------------------------------
    // Common anode select and segment lookup
    // ------------------------------------------------------------

    assign com       = ~(4'b0001 << digit_idx);
    assign cur_digit = disp.digit[digit_idx];

    // Blank on a non BCD nibble
    assign seg = (cur_digit > 4'd9) ? 8'hFF : SEG_TABLE[cur_digit];

    a_one_digit_on: assert property (@(posedge clk) disable iff (reset_p)
        $countones(com) == 3);

endmodule

//--- rtl/kitchen_clock_top.sv
`timescale 1ns/1ps

module kitchen_clock_top #(
    parameter int TICKS_PER_SEC = 100_000_000,
    parameter int SCAN_CYCLES   = 100_000
) (
    input  logic       clk,
    input  logic       reset_p,
    input  logic [3:0] button,     // run, inc_sec, inc_min, face
    input  logic       alarm_off,  // Slide switch
    output logic [7:0] seg,
    output logic [3:0] com,
    output logic [3:0] led,
    output logic       buz
);

    import clock_pkg::*;

    face_btn_t     watch_btn;
    face_btn_t     cook_btn;
    face_t         face;
    logic          tick;
    clock_time_t   watch_time;
    clock_time_t   cook_time;
    logic          watch_running;
    logic          cook_running;
    logic          alarm;
    display_word_u disp;

    panel_control #(.TICKS_PER_SEC(TICKS_PER_SEC)) u_panel (
        .clk(clk), .reset_p(reset_p), .button(button),
        .watch_btn(watch_btn), .cook_btn(cook_btn),
        .face(face), .tick(tick)
    );

    watch_core u_watch (
        .clk(clk), .reset_p(reset_p), .btn(watch_btn), .tick(tick),
        .time_out(watch_time), .running(watch_running)
    );

    cook_timer u_cook (
        .clk(clk), .reset_p(reset_p), .btn(cook_btn), .tick(tick),
        .alarm_off(alarm_off), .time_out(cook_time),
        .running(cook_running), .alarm(alarm)
    );

    display_mux u_mux (
        .face(face), .watch_time(watch_time), .cook_time(cook_time), .disp(disp)
    );

    fnd_scan #(.SCAN_CYCLES(SCAN_CYCLES)) u_fnd (
        .clk(clk), .reset_p(reset_p), .disp(disp), .seg(seg), .com(com)
    );

    assign led[0] = (face == FACE_WATCH);  // Watch face on show
    assign led[1] = alarm;
    assign led[2] = watch_running;
    assign led[3] = cook_running;
    assign buz    = alarm;

endmodule

//--- bench/tb_checker.sv
`timescale 1ns/1ps

module tb_checker #(
    parameter int TICKS_PER_SEC = 40,
    parameter int SCAN_CYCLES   = 4
) (
    input  logic       clk,
    input  logic       reset_p,
    input  logic [3:0] button,
    input  logic       alarm_off,
    input  logic [7:0] seg,
    input  logic [3:0] com,
    input  logic [3:0] led,
    input  logic       buz,
    output int         err_count
);

    import clock_pkg::*;

    logic [3:0] b_now;    // Buttons as sampled last edge
    logic [3:0] b_old;
    int         t_cnt;
    logic       m_face;   // High while the cook face is shown
    logic       w_run;
    int         w_sec;
    int         w_min;
    logic       c_run;
    int         c_sec;
    int         c_min;
    logic       m_alarm;
    int         s_cnt;
    logic [1:0] s_idx;
    int         errors = 0;

    assign err_count = errors;

    // ------------------------------------------------------------
    // Reference model, stepped on the DUT's edges
    // ------------------------------------------------------------

    task automatic clear_model();
        b_now   = 4'h0;
        b_old   = 4'h0;
        t_cnt   = 0;
        m_face  = 1'b0;
        w_run   = 1'b1;   // Watch runs out of reset
        w_sec   = 0;
        w_min   = 0;
        c_run   = 1'b0;
        c_sec   = 0;
        c_min   = 0;
        m_alarm = 1'b0;
        s_cnt   = 0;
        s_idx   = 2'd0;
    endtask

    task automatic step_model();
        logic [3:0] rise;
        logic [2:0] p;
        logic       tk;
        logic       go;
        logic       hit;
        rise = b_now & ~b_old;   // Pulse one cycle after the sample
        p    = rise[2:0];
        tk   = (t_cnt == TICKS_PER_SEC - 1);
        // Watch face
        go = w_run ^ (p[0] & ~m_face);
        if (!m_face && (p[1] || p[2])) begin
            w_sec = p[1] ? (w_sec + 1) % 60 : w_sec;
            w_min = p[2] ? (w_min + 1) % 60 : w_min;
        end else if (tk && go) begin
            w_min = (w_sec == 59) ? (w_min + 1) % 60 : w_min;
            w_sec = (w_sec + 1) % 60;
        end
        w_run = go;
        // Cook face, settable only while stopped
        go  = c_run ? !(p[0] & m_face) : (p[0] & m_face & (c_min + c_sec != 0));
        hit = 1'b0;
        if (m_face && !c_run && (p[1] || p[2])) begin
            c_sec = p[1] ? (c_sec + 1) % 60 : c_sec;
            c_min = p[2] ? (c_min + 1) % 60 : c_min;
        end else if (tk && go) begin
            c_min = (c_sec == 0) ? c_min - 1 : c_min;
            c_sec = (c_sec == 0) ? 59 : c_sec - 1;
            hit   = (c_min == 0 && c_sec == 0);
        end
        c_run   = go & ~hit;
        m_alarm = alarm_off ? 1'b0 : (m_alarm | hit);
        m_face  = m_face ^ rise[3];
        t_cnt   = tk ? 0 : t_cnt + 1;
        s_idx   = (s_cnt == SCAN_CYCLES - 1) ? s_idx + 2'd1 : s_idx;
        s_cnt   = (s_cnt + 1) % SCAN_CYCLES;
        b_old   = b_now;
        b_now   = button;
    endtask

    always @(posedge clk or posedge reset_p) begin
        if (reset_p) begin
            clear_model();
        end else begin
            step_model();
        end
    end

    // ------------------------------------------------------------
    // Output comparison, away from the active edge
    // ------------------------------------------------------------

    task automatic compare_value(input string name, input logic [7:0] exp, input logic [7:0] got);
        if (got !== exp) begin
            $display("MISMATCH at %0t ns: %s expected %h, got %h", $time, name, exp, got);
            errors++;
        end
    endtask

    task automatic check_outputs();
        int         mins;
        int         secs;
        int         d;
        logic [3:0] sel;
        mins = m_face ? c_min : w_min;
        secs = m_face ? c_sec : w_sec;
        case (s_idx)
            2'd0: begin
                d   = secs % 10;   // Rightmost digit
                sel = 4'b1110;
            end
            2'd1: begin
                d   = secs / 10;
                sel = 4'b1101;
            end
            2'd2: begin
                d   = mins % 10;
                sel = 4'b1011;
            end
            default: begin
                d   = mins / 10;
                sel = 4'b0111;
            end
        endcase
        compare_value("seg", SEG_TABLE[4'(d)], seg);
        compare_value("com", {4'h0, sel}, {4'h0, com});
        compare_value("led", {4'h0, c_run, w_run, m_alarm, ~m_face}, {4'h0, led});
        compare_value("buz", {7'h0, m_alarm}, {7'h0, buz});
    endtask

    always @(negedge clk) begin
        if (!reset_p) begin
            check_outputs();
        end
    end

endmodule

//--- bench/tb_top.sv
`timescale 1ns/1ps

module tb_top;

    import clock_pkg::*;

    localparam int TICKS   = 40;
    localparam int SCAN    = 4;
    localparam int PRESSES = 16;   // Random presses in the routing test

    logic        clk;
    logic        reset_p;
    logic [3:0]  button;
    logic        alarm_off;
    logic [7:0]  seg;
    logic [3:0]  com;
    logic [3:0]  led;
    logic        buz;
    int          err_count;
    logic [15:0] lfsr;
    int          other_fails = 0;
    int          tests_failed = 0;
    int          mark;

    kitchen_clock_top #(.TICKS_PER_SEC(TICKS), .SCAN_CYCLES(SCAN)) dut0 (
        .clk(clk), .reset_p(reset_p), .button(button), .alarm_off(alarm_off),
        .seg(seg), .com(com), .led(led), .buz(buz)
    );

    tb_checker #(.TICKS_PER_SEC(TICKS), .SCAN_CYCLES(SCAN)) chk0 (
        .clk(clk), .reset_p(reset_p), .button(button), .alarm_off(alarm_off),
        .seg(seg), .com(com), .led(led), .buz(buz),
        .err_count(err_count)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // ------------------------------------------------------------
    // Random bits and button presses
    // ------------------------------------------------------------

    // Taps for x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic take_bits(input int n, output int value);
        value = 0;
        for (int i = 0; i < n; i++) begin
            lfsr  = lfsr_step(lfsr);   // One step per bit
            value = value * 2 + (lfsr[0] ? 1 : 0);
        end
    endtask

    // Held two cycles, then low for 3 to 10 cycles
    task automatic press(input logic [1:0] idx);
        int gap;
        @(posedge clk);
        button[idx] <= 1'b1;
        repeat (2) @(posedge clk);
        button[idx] <= 1'b0;
        take_bits(3, gap);
        repeat (gap + 2) @(posedge clk);
    endtask

    task automatic wait_led(input logic [1:0] idx, input logic level, input int limit,
                            input string what);
        int n;
        n = 0;
        @(negedge clk);
        while (led[idx] !== level && n < limit) begin
            @(negedge clk);
            n++;
        end
        if (led[idx] !== level) begin
            $display("[%0t] timeout: %s did not happen within %0d cycles", $time, what, limit);
            other_fails++;
        end
    endtask

    // Minute ones digit sits at scan position 2
    task automatic wait_shown_minute(input int target, input int limit);
        int   n;
        logic shown;
        n     = 0;
        @(negedge clk);
        shown = (com == 4'b1011) && (seg == SEG_TABLE[target]);
        while (!shown && n < limit) begin
            @(negedge clk);
            n++;
            shown = (com == 4'b1011) && (seg == SEG_TABLE[target]);
        end
        if (!shown) begin
            $display("[%0t] timeout: watch never showed minute %0d", $time, target);
            other_fails++;
        end
    endtask

    task automatic begin_test();
        mark = err_count + other_fails;
    endtask

    task automatic end_test(input string name);
        int n;
        n = err_count + other_fails - mark;
        if (n != 0) begin
            tests_failed++;
        end
        $display("[%0t] test %s: %s (%0d errors)", $time, name, (n == 0) ? "ok" : "FAILED", n);
    endtask

    // ------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------

    initial begin
        int r;
        reset_p   = 1'b1;
        button    = 4'h0;
        alarm_off = 1'b0;
        lfsr      = 16'd21009;
        repeat (4) @(posedge clk);
        reset_p <= 1'b0;

        begin_test();
        repeat (3) @(posedge clk);
        end_test("reset_state");

        begin_test();
        wait_shown_minute(1, 3000);   // Through 00:59 into 01:00
        end_test("watch_running");

        begin_test();
        press(2'd3);            // Over to the cook face
        press(2'd0);            // Ignored at 00:00
        press(2'd2);
        take_bits(2, r);
        repeat (r + 2) press(2'd1);
        press(2'd0);
        wait_led(2'd3, 1'b1, 20, "cook timer start");
        press(2'd1);            // No effect while counting
        press(2'd2);
        press(2'd0);            // Pause, then go on
        press(2'd0);
        end_test("cook_timer");

        begin_test();
        wait_led(2'd1, 1'b1, 4000, "cook alarm");
        repeat (10) @(posedge clk);
        alarm_off <= 1'b1;
        @(posedge clk);
        alarm_off <= 1'b0;
        wait_led(2'd1, 1'b0, 10, "alarm clear");
        end_test("alarm");

        begin_test();
        for (int i = 0; i < PRESSES; i++) begin
            take_bits(2, r);
            press(2'(r));
        end
        end_test("routing");

        begin_test();
        repeat (8 * SCAN) @(posedge clk);
        end_test("scan");

        $display("summary: %0d of 6 tests failed, %0d compare errors, %0d other failures",
                 tests_failed, err_count, other_fails);
        if (tests_failed == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

//--- kitchen_clock.f
rtl/clock_pkg.sv
rtl/panel_control.sv
rtl/watch_core.sv
rtl/cook_timer.sv
rtl/display_mux.sv
rtl/fnd_scan.sv
rtl/kitchen_clock_top.sv
bench/tb_checker.sv
bench/tb_top.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        ?= tb_top
RTL_TOP    ?= kitchen_clock_top
FILELIST   ?= kitchen_clock.f
BUILD_DIR  ?= obj_dir
LINT_FLAGS ?= -Wall
SIM_FLAGS  ?= --binary --timing --assert -j 0
PASS_MSG   ?= Verification passed
RTL_SRCS   ?= rtl/clock_pkg.sv rtl/panel_control.sv rtl/watch_core.sv \
              rtl/cook_timer.sv rtl/display_mux.sv rtl/fnd_scan.sv \
              rtl/kitchen_clock_top.sv

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(LINT_FLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	@out=$$(./$(BUILD_DIR)/V$(TOP)); echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
